/* src/axil_config.svh */
//--------------------------------------------------------------------------
// AXI-Lite master widths
// address, data and byte-strobe sizes shared by package and testbench
//--------------------------------------------------------------------------
`ifndef AXIL_CONFIG_SVH
`define AXIL_CONFIG_SVH

//--------------------------------------------------------------------------
// bus widths
//--------------------------------------------------------------------------

// byte address
`define AXIL_ADDR_W 32

// one data word
`define AXIL_DATA_W 32

// one strobe bit per data byte
`define AXIL_STRB_W (`AXIL_DATA_W / 8)

`endif

/* src/axil_pkg.sv */
//--------------------------------------------------------------------------
// AXI-Lite master types
// vector typedefs, channel payload structs and the two channel FSM states
//--------------------------------------------------------------------------
package axil_pkg;

    `include "axil_config.svh"

    //----------------------------------------------------------------------
    // plain vectors
    //----------------------------------------------------------------------

    // byte address on AW and AR
    typedef logic [`AXIL_ADDR_W-1:0] addr_t;
    // one word on W and R
    typedef logic [`AXIL_DATA_W-1:0] data_t;
    // byte-lane enables
    typedef logic [`AXIL_STRB_W-1:0] strb_t;

    //----------------------------------------------------------------------
    // grouped payloads
    //----------------------------------------------------------------------

    // write request held while AW, W and B run
    typedef struct packed {
        addr_t addr;
        data_t data;
        strb_t strb;
    } wr_req_t;

    // W channel payload
    typedef struct packed {
        data_t data;
        strb_t strb;
    } axil_w_t;

    // read path report, fire marks the R handshake cycle
    typedef struct packed {
        logic  fire;
        data_t data;
    } rd_result_t;

    //----------------------------------------------------------------------
    // channel states
    //----------------------------------------------------------------------
    typedef enum logic [1:0] {w_idle, w_addr_data, w_resp} wr_state_e;
    typedef enum logic [1:0] {r_idle, r_addr, r_data} rd_state_e;

endpackage

/* src/axil_write_channel.sv */
//--------------------------------------------------------------------------
// AXI-Lite write path
// latches one write request and runs AW and W in any order, then B
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module axil_write_channel (
    input  logic              aclk,
    input  logic              areset_n,
    // user request
    input  logic              start_write,
    input  axil_pkg::addr_t   addr,
    input  axil_pkg::data_t   data,
    input  axil_pkg::strb_t   wstrb,
    // write address
    output logic              awvalid,
    input  logic              awready,
    output axil_pkg::addr_t   awaddr,
    // write data
    output logic              wvalid,
    input  logic              wready,
    output axil_pkg::axil_w_t w_chan,
    // write response
    input  logic              bvalid,
    output logic              bready,
    // report to status
    output logic              wr_fire,
    output logic              wr_active
);
    import axil_pkg::*;

    wr_state_e state;
    wr_req_t   req;
    // set once the matching handshake has gone through
    logic      aw_done;
    logic      w_done;
    // handshakes in this cycle
    logic      aw_fire;
    logic      w_fire;
    // handshake seen now or earlier
    logic      aw_ok;
    logic      w_ok;

    //----------------------------------------------------------------------
    // request latch
    //----------------------------------------------------------------------

    // only loaded in idle, so payload holds while valids are up
    always_ff @(posedge aclk) begin
        if (state == w_idle && start_write) begin
            req <= '{addr: addr, data: data, strb: wstrb};
        end
    end

    //----------------------------------------------------------------------
    // channel FSM
    //----------------------------------------------------------------------
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign aw_ok   = aw_done || aw_fire;
    assign w_ok    = w_done || w_fire;

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            state   <= w_idle;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                w_idle: begin
                    if (start_write) begin
                        state <= w_addr_data;
                    end
                end
                w_addr_data: begin
                    // AW and W may land in different cycles
                    if (aw_ok && w_ok) begin
                        state   <= w_resp;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end else begin
                        aw_done <= aw_ok;
                        w_done  <= w_ok;
                    end
                end
                w_resp: begin
                    if (bvalid) begin
                        state <= w_idle;
                    end
                end
                default: state <= w_idle;
            endcase
        end
    end

    //----------------------------------------------------------------------
    // outputs
    //----------------------------------------------------------------------

    // each valid drops after its own transfer
    assign awvalid   = (state == w_addr_data) && !aw_done;
    assign wvalid    = (state == w_addr_data) && !w_done;
    assign awaddr    = req.addr;
    assign w_chan    = '{data: req.data, strb: req.strb};
    assign bready    = (state == w_resp);
    // B handshake, one cycle
    assign wr_fire   = bready && bvalid;
    assign wr_active = (state != w_idle);

endmodule

/* src/axil_read_channel.sv */
//--------------------------------------------------------------------------
// AXI-Lite read path
// latches one read address, runs AR then R, reports the returned word
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module axil_read_channel (
    input  logic                 aclk,
    input  logic                 areset_n,
    // user request
    input  logic                 start_read,
    input  axil_pkg::addr_t      addr,
    // read address
    output logic                 arvalid,
    input  logic                 arready,
    output axil_pkg::addr_t      araddr,
    // read data
    input  logic                 rvalid,
    output logic                 rready,
    input  axil_pkg::data_t      rdata,
    // report to status
    output axil_pkg::rd_result_t rd_res,
    output logic                 rd_active
);
    import axil_pkg::*;

    rd_state_e state;
    addr_t     addr_q;

    //----------------------------------------------------------------------
    // address latch
    //----------------------------------------------------------------------

    // loaded only in idle, ARADDR stays put while ARVALID is high
    always_ff @(posedge aclk) begin
        if (state == r_idle && start_read) begin
            addr_q <= addr;
        end
    end

    //----------------------------------------------------------------------
    // channel FSM
    //----------------------------------------------------------------------
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            state <= r_idle;
        end else begin
            case (state)
                r_idle: begin
                    // start while busy falls through here unseen
                    if (start_read) begin
                        state <= r_addr;
                    end
                end
                r_addr: begin
                    if (arready) begin
                        state <= r_data;
                    end
                end
                r_data: begin
                    if (rvalid) begin
                        state <= r_idle;
                    end
                end
                default: state <= r_idle;
            endcase
        end
    end

    //----------------------------------------------------------------------
    // outputs
    //----------------------------------------------------------------------
    assign arvalid     = (state == r_addr);
    assign araddr      = addr_q;
    assign rready      = (state == r_data);
    // R handshake and its word
    assign rd_res.fire = rready && rvalid;
    assign rd_res.data = rdata;
    assign rd_active   = (state != r_idle);

endmodule

/* src/axil_master_status.sv */
//--------------------------------------------------------------------------
// AXI-Lite master status
// keeps the last read word and turns channel events into done and busy
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module axil_master_status (
    input  logic                 aclk,
    input  logic                 areset_n,
    // from the read path
    input  axil_pkg::rd_result_t rd_res,
    input  logic                 rd_active,
    // from the write path
    input  logic                 wr_fire,
    input  logic                 wr_active,
    // to the user
    output axil_pkg::data_t      rdata,
    output logic                 rd_done,
    output logic                 wr_done,
    output logic                 rd_busy,
    output logic                 wr_busy
);
    import axil_pkg::*;

    //----------------------------------------------------------------------
    // read data capture
    //----------------------------------------------------------------------

    // holds until the next R handshake
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            rdata <= '0;
        end else if (rd_res.fire) begin
            rdata <= rd_res.data;
        end
    end

    //----------------------------------------------------------------------
    // done pulses
    //----------------------------------------------------------------------

    // one cycle after the R or B handshake edge
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            rd_done <= 1'b0;
            wr_done <= 1'b0;
        end else begin
            rd_done <= rd_res.fire;
            wr_done <= wr_fire;
        end
    end

    //----------------------------------------------------------------------
    // busy levels
    //----------------------------------------------------------------------

    // channel active, one cycle late
    // cut on the final handshake so busy falls as done rises
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            rd_busy <= 1'b0;
            wr_busy <= 1'b0;
        end else begin
            rd_busy <= rd_active && !rd_res.fire;
            wr_busy <= wr_active && !wr_fire;
        end
    end

endmodule

/* src/axil_master.sv */
//--------------------------------------------------------------------------
// AXI-Lite single master, one read and one write in flight
// write path, read path and status block joined to the user and bus ports
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module axil_master (
    input  logic              aclk,
    input  logic              areset_n,
    // user side
    input  logic              start_write,
    input  logic              start_read,
    input  axil_pkg::addr_t   addr,
    input  axil_pkg::data_t   data,
    input  axil_pkg::strb_t   wstrb,
    // write address
    output logic              awvalid,
    input  logic              awready,
    output axil_pkg::addr_t   awaddr,
    // write data
    output logic              wvalid,
    input  logic              wready,
    output axil_pkg::axil_w_t w_chan,
    // write response
    input  logic              bvalid,
    output logic              bready,
    // read address
    output logic              arvalid,
    input  logic              arready,
    output axil_pkg::addr_t   araddr,
    // read data, bus RDATA is s_rdata so it can sit beside the user rdata
    input  logic              rvalid,
    output logic              rready,
    input  axil_pkg::data_t   s_rdata,
    // user results
    output axil_pkg::data_t   rdata,
    output logic              rd_done,
    output logic              wr_done,
    output logic              rd_busy,
    output logic              wr_busy
);
    import axil_pkg::*;

    // path reports into status
    logic       wr_fire;
    logic       wr_active;
    rd_result_t rd_res;
    logic       rd_active;

    //----------------------------------------------------------------------
    // channel paths
    //----------------------------------------------------------------------
    axil_write_channel wr_chan_i (
        .aclk        (aclk),
        .areset_n    (areset_n),
        .start_write (start_write),
        .addr        (addr),
        .data        (data),
        .wstrb       (wstrb),
        .awvalid     (awvalid),
        .awready     (awready),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wready      (wready),
        .w_chan      (w_chan),
        .bvalid      (bvalid),
        .bready      (bready),
        .wr_fire     (wr_fire),
        .wr_active   (wr_active)
    );

    axil_read_channel rd_chan_i (
        .aclk       (aclk),
        .areset_n   (areset_n),
        .start_read (start_read),
        .addr       (addr),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (s_rdata),
        .rd_res     (rd_res),
        .rd_active  (rd_active)
    );

    //----------------------------------------------------------------------
    // user status
    //----------------------------------------------------------------------
    axil_master_status status_i (
        .aclk      (aclk),
        .areset_n  (areset_n),
        .rd_res    (rd_res),
        .rd_active (rd_active),
        .wr_fire   (wr_fire),
        .wr_active (wr_active),
        .rdata     (rdata),
        .rd_done   (rd_done),
        .wr_done   (wr_done),
        .rd_busy   (rd_busy),
        .wr_busy   (wr_busy)
    );

endmodule

/* test/axil_slave_model.sv */
//--------------------------------------------------------------------------
// AXI-Lite slave model with word memory and random ready and valid delays
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module axil_slave_model #(
    parameter int          MEM_DEPTH = 16,
    parameter logic [31:0] SEED      = 32'd11
) (
    input  logic              aclk,
    input  logic              areset_n,
    input  logic              awvalid,
    output logic              awready,
    input  axil_pkg::addr_t   awaddr,
    input  logic              wvalid,
    output logic              wready,
    input  axil_pkg::axil_w_t w_chan,
    output logic              bvalid,
    input  logic              bready,
    input  logic              arvalid,
    output logic              arready,
    input  axil_pkg::addr_t   araddr,
    output logic              rvalid,
    input  logic              rready,
    output axil_pkg::data_t   rdata,
    output int                b_count
);
    import axil_pkg::*;

    data_t       mem [MEM_DEPTH];
    logic [31:0] rng;
    // held write request
    addr_t       aw_addr;
    axil_w_t     w_q;
    logic        aw_got;
    logic        w_got;
    logic        ar_got;
    // per channel wait counters
    logic [1:0]  aw_dly;
    logic [1:0]  w_dly;
    logic [1:0]  b_dly;
    logic [1:0]  ar_dly;
    logic [1:0]  r_dly;
    int          i;

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1103515245 + 32'd12345;
    endfunction

    // fill pattern, every word differs
    function automatic data_t fill_word(input int idx);
        return 32'hc0de_0000 ^ (idx * 32'h0103_0507);
    endfunction

    always @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            rng     <= SEED;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            ar_got  <= 1'b0;
            aw_dly  <= 2'd0;
            w_dly   <= 2'd1;
            b_dly   <= 2'd2;
            ar_dly  <= 2'd1;
            r_dly   <= 2'd0;
            b_count <= 0;
            for (i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= fill_word(i);
            end
        end else begin
            rng <= lcg_next(rng);
            // AW ready after its delay, held until the handshake
            if (awvalid && awready) begin
                awready <= 1'b0;
                aw_addr <= awaddr;
                aw_got  <= 1'b1;
            end else if (awvalid) begin
                if (aw_dly == 0) begin
                    awready <= 1'b1;
                    aw_dly  <= rng[17:16];
                end else begin
                    aw_dly <= aw_dly - 1;
                end
            end
            // W channel
            if (wvalid && wready) begin
                wready <= 1'b0;
                w_q    <= w_chan;
                w_got  <= 1'b1;
            end else if (wvalid) begin
                if (w_dly == 0) begin
                    wready <= 1'b1;
                    w_dly  <= rng[19:18];
                end else begin
                    w_dly <= w_dly - 1;
                end
            end
            // merge under strobes, then answer on B
            if (bvalid && bready) begin
                bvalid  <= 1'b0;
                b_count <= b_count + 1;
            end else if (aw_got && w_got && !bvalid) begin
                if (b_dly == 0) begin
                    for (i = 0; i < 4; i++) begin
                        if (w_q.strb[i]) begin
                            mem[aw_addr[5:2]][8*i +: 8] <= w_q.data[8*i +: 8];
                        end
                    end
                    bvalid <= 1'b1;
                    aw_got <= 1'b0;
                    w_got  <= 1'b0;
                    b_dly  <= rng[21:20];
                end else begin
                    b_dly <= b_dly - 1;
                end
            end
            // AR, word taken at the handshake
            if (arvalid && arready) begin
                arready <= 1'b0;
                rdata   <= mem[araddr[5:2]];
                ar_got  <= 1'b1;
            end else if (arvalid) begin
                if (ar_dly == 0) begin
                    arready <= 1'b1;
                    ar_dly  <= rng[23:22];
                end else begin
                    ar_dly <= ar_dly - 1;
                end
            end
            // R channel
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if (ar_got && !rvalid) begin
                if (r_dly == 0) begin
                    rvalid <= 1'b1;
                    ar_got <= 1'b0;
                    r_dly  <= rng[25:24];
                end else begin
                    r_dly <= r_dly - 1;
                end
            end
        end
    end

endmodule

/* test/tb_axil_master.sv */
//--------------------------------------------------------------------------
// testbench for the AXI-Lite master against a random-delay slave model
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module tb_axil_master;
    import axil_pkg::*;

    localparam int MEM_DEPTH      = 16;
    localparam int NUM_RANDOM_OPS = 40;
    localparam int RESET_CYCLES   = 4;
    localparam int TOTAL_OPS      = NUM_RANDOM_OPS + 12;
    localparam int CYCLE_LIMIT    = TOTAL_OPS * 20 + RESET_CYCLES;
    localparam int DONE_LIMIT     = 40;

    logic    aclk;
    logic    areset_n;
    logic    start_write;
    logic    start_read;
    addr_t   addr;
    data_t   data;
    strb_t   wstrb;
    logic    awvalid, awready, wvalid, wready, bvalid, bready;
    logic    arvalid, arready, rvalid, rready;
    addr_t   awaddr, araddr;
    axil_w_t w_chan;
    data_t   s_rdata, rdata;
    logic    rd_done, wr_done, rd_busy, wr_busy;
    int      b_count;

    data_t       shadow [MEM_DEPTH];
    logic [31:0] rng;
    int          errors, checks, tests, cycles;
    int          wr_starts, rd_starts, wr_dones, rd_dones;

    axil_master dut_i (
        .aclk(aclk), .areset_n(areset_n),
        .start_write(start_write), .start_read(start_read),
        .addr(addr), .data(data), .wstrb(wstrb),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .w_chan(w_chan),
        .bvalid(bvalid), .bready(bready),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .s_rdata(s_rdata),
        .rdata(rdata), .rd_done(rd_done), .wr_done(wr_done),
        .rd_busy(rd_busy), .wr_busy(wr_busy)
    );

    axil_slave_model #(.MEM_DEPTH(MEM_DEPTH), .SEED(32'd11)) slave_i (
        .aclk(aclk), .areset_n(areset_n),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .w_chan(w_chan),
        .bvalid(bvalid), .bready(bready),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(s_rdata),
        .b_count(b_count)
    );

    always #20 aclk = ~aclk;

    //----------------------------------------------------------------------
    // reference model and checks
    //----------------------------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1103515245 + 32'd12345;
    endfunction

    // slave power-up contents
    function automatic data_t initial_word(input int idx);
        return 32'hc0de_0000 ^ (idx * 32'h0103_0507);
    endfunction

    // byte-lane merge of a write into a word
    function automatic data_t merge_write(input data_t old, input data_t wd, input strb_t s);
        data_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) res[8*b +: 8] = wd[8*b +: 8];
        end
        return res;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    // done seen at a falling edge, where outputs are settled
    task automatic wait_done(input string name, input bit is_write);
        int n;
        n = 0;
        while (!(is_write ? wr_done : rd_done) && n < DONE_LIMIT) begin
            @(negedge aclk);
            n++;
        end
        if (!(is_write ? wr_done : rd_done)) begin
            errors++;
            $display("%s: timeout waiting for done", name);
        end else begin
            // busy drops in the same cycle done rises
            compare({name, "_busy_low"}, 0, is_write ? wr_busy : rd_busy);
        end
    endtask

    task automatic pulse_write(input int idx, input data_t wd, input strb_t s);
        @(negedge aclk);
        start_write = 1'b1;
        addr = idx * 4;
        data = wd;
        wstrb = s;
        wr_starts++;
        shadow[idx] = merge_write(shadow[idx], wd, s);
        @(negedge aclk);
        start_write = 1'b0;
    endtask

    task automatic pulse_read(input int idx);
        @(negedge aclk);
        start_read = 1'b1;
        addr = idx * 4;
        rd_starts++;
        @(negedge aclk);
        start_read = 1'b0;
    endtask

    task automatic do_write(input string name, input int idx, input data_t wd, input strb_t s);
        pulse_write(idx, wd, s);
        // busy follows the channel state one cycle later
        @(negedge aclk);
        compare({name, "_busy"}, 1, wr_busy);
        wait_done(name, 1'b1);
    endtask

    task automatic do_read(input string name, input int idx);
        pulse_read(idx);
        @(negedge aclk);
        compare({name, "_busy"}, 1, rd_busy);
        wait_done(name, 1'b0);
        compare(name, shadow[idx], rdata);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s finished, errors so far %0d", name, errors);
    endtask

    //----------------------------------------------------------------------
    // done pulse counting and run limit
    //----------------------------------------------------------------------
    always @(negedge aclk) begin
        if (wr_done) wr_dones++;
        if (rd_done) rd_dones++;
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("run stopped, cycle limit %0d reached", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    //----------------------------------------------------------------------
    // stimulus
    //----------------------------------------------------------------------
    initial begin
        int idx;
        int b_before;
        aclk = 1'b0;
        areset_n = 1'b0;
        start_write = 1'b0;
        start_read = 1'b0;
        addr = '0;
        data = '0;
        wstrb = '0;
        rng = 32'd11;
        errors = 0;
        checks = 0;
        tests = 0;
        cycles = 0;
        wr_starts = 0;
        rd_starts = 0;
        wr_dones = 0;
        rd_dones = 0;
        for (int i = 0; i < MEM_DEPTH; i++) shadow[i] = initial_word(i);
        repeat (RESET_CYCLES) @(negedge aclk);
        areset_n = 1'b1;

        @(negedge aclk);
        compare("reset_state", '0, {awvalid, wvalid, bready, arvalid, rready,
                                    rd_done, wr_done, rd_busy, wr_busy});
        compare("reset_rdata", '0, rdata);
        end_test("reset_state");

        do_write("full_word_write", 3, 32'h1234_5678, 4'hf);
        do_read("full_word_read", 3);
        end_test("full_word");

        do_write("partial_write", 5, 32'haabb_ccdd, 4'b0101);
        do_read("partial_read", 5);
        end_test("partial_strobes");

        for (int k = 0; k < NUM_RANDOM_OPS; k++) begin
            rng = lcg_next(rng);
            idx = rng[27:24];
            if (rng[31]) begin
                do_write("random_write", idx, lcg_next(rng), rng[7:4]);
            end else begin
                do_read("random_read", idx);
            end
        end
        end_test("random_traffic");

        // the user address is shared, so the read starts one cycle later
        @(negedge aclk);
        start_write = 1'b1;
        addr = 7 * 4;
        data = 32'hdead_beef;
        wstrb = 4'hf;
        wr_starts++;
        @(negedge aclk);
        start_write = 1'b0;
        start_read = 1'b1;
        addr = 9 * 4;
        rd_starts++;
        @(negedge aclk);
        start_read = 1'b0;
        fork
            wait_done("duplex_write", 1'b1);
            begin
                wait_done("duplex_read", 1'b0);
                compare("duplex_read", shadow[9], rdata);
            end
        join
        shadow[7] = merge_write(shadow[7], 32'hdead_beef, 4'hf);
        do_read("duplex_readback", 7);
        end_test("full_duplex");

        b_before = b_count;
        pulse_write(2, 32'h0bad_f00d, 4'hf);
        @(negedge aclk);
        compare("ignored_busy", 1, wr_busy);
        start_write = 1'b1;
        addr = 4 * 4;
        data = 32'h5555_aaaa;
        wstrb = 4'hf;
        @(negedge aclk);
        start_write = 1'b0;
        wait_done("ignored_first", 1'b1);
        repeat (10) @(negedge aclk);
        compare("ignored_b_count", b_before + 1, b_count);
        do_read("ignored_untouched", 4);
        do_read("ignored_first_word", 2);
        end_test("ignored_start");

        repeat (4) @(negedge aclk);
        compare("write_done_count", wr_starts, wr_dones);
        compare("read_done_count", rd_starts, rd_dones);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+src
src/axil_pkg.sv
src/axil_write_channel.sv
src/axil_read_channel.sv
src/axil_master_status.sv
src/axil_master.sv
test/axil_slave_model.sv
test/tb_axil_master.sv
